// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f compile.f --top-module tb_pkt_replay -Mdir obj_dir -o sim
	-./obj_dir/sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Finished with no errors" sim.log; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+design
design/replay_pkg.sv
design/ctrl_sync.sv
design/pkt_capture.sv
design/pkt_replay.sv
design/replay_mem.sv
design/stream_rebuild.sv
design/pkt_replay_top.sv
tests/tb_clkgen.sv
tests/tb_pkt_replay.sv

// ==== design/ctrl_sync.sv ====
// Control level synchroniser
`timescale 1ns/1ps

module ctrl_sync (
   input  logic clk,
   input  logic rst_clk,
   input  logic start_replay_i,
   input  logic sw_rst_i,
   output logic start_p_o,
   output logic clear_p_o,
   output logic hold_o
);

   logic [2:0] start_sr_q;
   logic [2:0] clr_sr_q;
   // Bit 0 start, bit 1 clear
   logic [1:0] rise_q;

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         start_sr_q <= '0;
         clr_sr_q   <= '0;
      end else begin
         start_sr_q <= {start_sr_q[1:0], start_replay_i};
         clr_sr_q   <= {clr_sr_q[1:0], sw_rst_i};
      end
   end

   // Pulse lands three clocks after the input edge
   always_ff @(posedge clk) begin
      if (rst_clk) begin
         rise_q <= '0;
      end else begin
         rise_q <= {clr_sr_q[1] & ~clr_sr_q[2], start_sr_q[1] & ~start_sr_q[2]};
      end
   end

   assign start_p_o = rise_q[0];
   assign clear_p_o = rise_q[1];

   // Clear level as seen in this domain, blocks new starts
   assign hold_o = clr_sr_q[2];

endmodule

// ==== design/pkt_capture.sv ====
// Packet capture into the store
`timescale 1ns/1ps
`include "replay_macros.svh"

module pkt_capture (
   input  logic                     clk,
   input  logic                     rst_clk,
   input  logic                     clear_i,
   input  replay_pkg::stream_beat_t in_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   output replay_pkg::mem_wr_t      mem_wr_o,
   output logic [`MEM_ADDR_W-1:0]   end_addr_o,
   output logic                     has_data_o
);
   import replay_pkg::*;

   typedef enum logic {
      ST_HDR,
      ST_DATA
   } cap_state_e;

   cap_state_e             state_q;
   logic [`MEM_ADDR_W-1:0] wr_addr_q;
   logic [`MEM_ADDR_W-1:0] end_addr_q;
   logic                   has_data_q;
   logic [BYTES_W-1:0]     byte_cnt;
   logic                   wr_en;
   mem_word_u              wr_word;

   // Keep is contiguous from byte 0, so its population count is the length
   always_comb begin
      byte_cnt = '0;
      for (int i = 0; i < `KEEP_W; i++) begin
         byte_cnt = byte_cnt + BYTES_W'(in_i.keep[i]);
      end
   end

   always_comb begin
      wr_word = '0;
      if (state_q == ST_HDR) begin
         wr_word.hdr.is_hdr = 1'b1;
         wr_word.hdr.user   = in_i.user;
      end else begin
         wr_word.dat.last  = in_i.last;
         wr_word.dat.bytes = byte_cnt;
         wr_word.dat.data  = in_i.data;
      end
   end

   // Header cycle writes without taking the beat
   assign wr_en      = in_valid_i & ~clear_i;
   assign in_ready_o = (state_q == ST_DATA) & ~clear_i;
   assign mem_wr_o   = '{en: wr_en, addr: wr_addr_q, word: wr_word};

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         state_q    <= ST_HDR;
         wr_addr_q  <= '0;
         end_addr_q <= '0;
         has_data_q <= 1'b0;
      end else if (wr_en) begin
         wr_addr_q  <= wr_addr_q + 1'b1;
         end_addr_q <= wr_addr_q;
         has_data_q <= 1'b1;
         if (state_q == ST_HDR) begin
            state_q <= ST_DATA;
         end else if (in_i.last) begin
            state_q <= ST_HDR;
         end
      end
   end

   assign end_addr_o = end_addr_q;
   assign has_data_o = has_data_q;

endmodule

// ==== design/pkt_replay.sv ====
// Replay read sequencer
`timescale 1ns/1ps
`include "replay_macros.svh"

module pkt_replay (
   input  logic                   clk,
   input  logic                   rst_clk,
   input  logic                   start_i,
   input  logic                   clear_i,
   input  logic                   hold_i,
   input  logic [`CNT_W-1:0]      replay_count_i,
   input  logic [`MEM_ADDR_W-1:0] end_addr_i,
   input  logic                   has_data_i,
   input  logic                   rd_space_i,
   output logic                   rd_en_o,
   output logic [`MEM_ADDR_W-1:0] rd_addr_o,
   output logic                   busy_o
);

   logic                   busy_q;
   logic [`MEM_ADDR_W-1:0] rd_addr_q;
   logic [`CNT_W-1:0]      pass_q;
   logic [`CNT_W-1:0]      count_q;
   logic [`CNT_W-1:0]      pass_next;
   logic                   rd_en;
   logic                   pass_end;

   // One read per cycle, only while the output FIFO has room
   assign rd_en     = busy_q & rd_space_i & ~clear_i;
   assign pass_end  = (rd_addr_q == end_addr_i);
   assign pass_next = pass_q + 1'b1;

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         busy_q    <= 1'b0;
         rd_addr_q <= '0;
         pass_q    <= '0;
         count_q   <= '0;
      end else if (!busy_q) begin
         if (start_i && !hold_i && has_data_i) begin
            busy_q    <= 1'b1;
            rd_addr_q <= '0;
            pass_q    <= '0;
            count_q   <= replay_count_i;
         end
      end else if (rd_en) begin
         if (pass_end) begin
            rd_addr_q <= '0;
            pass_q    <= pass_next;
            // Count of 0 stops here as well, giving a single pass
            busy_q    <= (pass_next < count_q);
         end else begin
            rd_addr_q <= rd_addr_q + 1'b1;
         end
      end
   end

   assign rd_en_o   = rd_en;
   assign rd_addr_o = rd_addr_q;
   assign busy_o    = busy_q;

endmodule

// ==== design/pkt_replay_top.sv ====
// Packet capture and replay engine
`timescale 1ns/1ps
`include "replay_macros.svh"

module pkt_replay_top (
   input  logic                     clk,
   input  logic                     rst_clk,
   input  replay_pkg::stream_beat_t in_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   output replay_pkg::stream_beat_t out_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i,
   input  logic                     start_replay_i,
   input  logic                     sw_rst_i,
   input  logic [`CNT_W-1:0]        replay_count_i,
   output logic                     busy_o
);
   import replay_pkg::*;

   logic                   start_p;
   logic                   clear_p;
   logic                   hold;
   mem_wr_t                mem_wr;
   logic [`MEM_ADDR_W-1:0] end_addr;
   logic                   has_data;
   logic                   rd_en;
   logic [`MEM_ADDR_W-1:0] rd_addr;
   logic                   rd_space;
   logic                   rd_valid;
   mem_word_u              rd_word;

   ctrl_sync u_ctrl_sync (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .start_replay_i (start_replay_i),
      .sw_rst_i       (sw_rst_i),
      .start_p_o      (start_p),
      .clear_p_o      (clear_p),
      .hold_o         (hold)
   );

   pkt_capture u_pkt_capture (
      .clk        (clk),
      .rst_clk    (rst_clk),
      .clear_i    (clear_p),
      .in_i       (in_i),
      .in_valid_i (in_valid_i),
      .in_ready_o (in_ready_o),
      .mem_wr_o   (mem_wr),
      .end_addr_o (end_addr),
      .has_data_o (has_data)
   );

   pkt_replay u_pkt_replay (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .start_i        (start_p),
      .clear_i        (clear_p),
      .hold_i         (hold),
      .replay_count_i (replay_count_i),
      .end_addr_i     (end_addr),
      .has_data_i     (has_data),
      .rd_space_i     (rd_space),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr),
      .busy_o         (busy_o)
   );

   // Capture writes and replay reads share the store
   replay_mem u_replay_mem (
      .clk        (clk),
      .mem_wr_i   (mem_wr),
      .rd_en_i    (rd_en),
      .rd_addr_i  (rd_addr),
      .rd_valid_o (rd_valid),
      .rd_word_o  (rd_word)
   );

   stream_rebuild u_stream_rebuild (
      .clk         (clk),
      .rst_clk     (rst_clk),
      .clear_i     (clear_p),
      .rd_valid_i  (rd_valid),
      .rd_word_i   (rd_word),
      .rd_space_o  (rd_space),
      .out_o       (out_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

// ==== design/replay_macros.svh ====
// Replay engine widths and depths
`ifndef REPLAY_MACROS_SVH
`define REPLAY_MACROS_SVH

// Stream beat fields
`define DATA_W 128
`define KEEP_W 16
`define USER_W 32

// 1024 store words of four 36-bit lanes
`define MEM_ADDR_W 10
`define MEM_WORD_W 144

// Replay pass count
`define CNT_W 16

// Output FIFO
`define OUT_FIFO_DEPTH 16
// Free entries needed before another read goes out
`define SPACE_MARGIN 4

`endif

// ==== design/replay_mem.sv ====
// Packet store RAM
`timescale 1ns/1ps
`include "replay_macros.svh"

module replay_mem (
   input  logic                   clk,
   input  replay_pkg::mem_wr_t    mem_wr_i,
   input  logic                   rd_en_i,
   input  logic [`MEM_ADDR_W-1:0] rd_addr_i,
   output logic                   rd_valid_o,
   output replay_pkg::mem_word_u  rd_word_o
);
   import replay_pkg::*;

   mem_word_u mem_q [2**`MEM_ADDR_W];
   mem_word_u rd_word_q;
   logic      rd_valid_q;

   always_ff @(posedge clk) begin
      if (mem_wr_i.en) begin
         mem_q[mem_wr_i.addr] <= mem_wr_i.word;
      end
   end

   // Fixed one cycle read latency
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_word_q <= mem_q[rd_addr_i];
      end
      rd_valid_q <= rd_en_i;
   end

   assign rd_valid_o = rd_valid_q;
   assign rd_word_o  = rd_word_q;

endmodule

// ==== design/replay_pkg.sv ====
// Replay engine types
`include "replay_macros.svh"

package replay_pkg;

   // Byte count field from 1 to 16
   localparam int BYTES_W = 5;
   // Unused bits above the header flag
   localparam int PAD_W   = `MEM_WORD_W - `DATA_W - BYTES_W - 2;
   // Gap between the header flag and the user word
   localparam int RSVD_W  = `DATA_W + BYTES_W + 1 - `USER_W;

   typedef struct packed {
      logic [`DATA_W-1:0] data;
      logic [`KEEP_W-1:0] keep;
      logic [`USER_W-1:0] user;
      logic               last;
   } stream_beat_t;

   typedef struct packed {
      logic [PAD_W-1:0]   pad;
      logic               is_hdr;
      logic [RSVD_W-1:0]  rsvd;
      logic [`USER_W-1:0] user;
   } hdr_view_t;

   typedef struct packed {
      logic [PAD_W-1:0]   pad;
      logic               is_hdr;
      logic               last;
      logic [BYTES_W-1:0] bytes;
      logic [`DATA_W-1:0] data;
   } data_view_t;

   // is_hdr lands on the same bit in both views
   typedef union packed {
      hdr_view_t  hdr;
      data_view_t dat;
   } mem_word_u;

   typedef struct packed {
      logic                   en;
      logic [`MEM_ADDR_W-1:0] addr;
      mem_word_u              word;
   } mem_wr_t;

endpackage

// ==== design/stream_rebuild.sv ====
// Store word to stream beat rebuild
`timescale 1ns/1ps
`include "replay_macros.svh"

module stream_rebuild (
   input  logic                      clk,
   input  logic                      rst_clk,
   input  logic                      clear_i,
   input  logic                      rd_valid_i,
   input  replay_pkg::mem_word_u     rd_word_i,
   output logic                      rd_space_o,
   output replay_pkg::stream_beat_t  out_o,
   output logic                      out_valid_o,
   input  logic                      out_ready_i
);
   import replay_pkg::*;

   localparam int PTR_W  = $clog2(`OUT_FIFO_DEPTH);
   localparam int FILL_W = PTR_W + 1;
   localparam logic [FILL_W-1:0] SPACE_LIMIT = FILL_W'(`OUT_FIFO_DEPTH - `SPACE_MARGIN);

   stream_beat_t       fifo_q [`OUT_FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr_q;
   logic [PTR_W-1:0]   rd_ptr_q;
   logic [FILL_W-1:0]  fill_q;
   logic [`USER_W-1:0] user_q;
   stream_beat_t       beat;
   logic               push;
   logic               pop;

   // Byte count back to a contiguous keep mask
   always_comb begin
      beat.data = rd_word_i.dat.data;
      for (int i = 0; i < `KEEP_W; i++) begin
         beat.keep[i] = (i < int'(rd_word_i.dat.bytes));
      end
      beat.user = user_q;
      beat.last = rd_word_i.dat.last;
   end

   assign push = rd_valid_i & ~rd_word_i.hdr.is_hdr;
   assign pop  = out_valid_o & out_ready_i;

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_q[wr_ptr_q] <= beat;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk || clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         user_q   <= '0;
      end else begin
         // User word rides on the first data beat only
         if (rd_valid_i) begin
            user_q <= rd_word_i.hdr.is_hdr ? rd_word_i.hdr.user : '0;
         end
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         fill_q <= fill_q + FILL_W'(push) - FILL_W'(pop);
      end
   end

   // First word fall-through
   assign out_valid_o = (fill_q != '0);
   assign out_o       = fifo_q[rd_ptr_q];

   // Leaves room for reads still in flight
   assign rd_space_o = (fill_q < SPACE_LIMIT);

endmodule

// ==== tests/tb_clkgen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk,
   output logic rst_clk
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held for four rising edges
   initial begin
      rst_clk = 1'b1;
      repeat (4) @(posedge clk);
      rst_clk <= 1'b0;
   end

endmodule

// ==== tests/tb_pkt_replay.sv ====
// Replay engine directed tests
`timescale 1ns/1ps
`include "replay_macros.svh"

module tb_pkt_replay;
   import replay_pkg::*;

   localparam int WAIT_LIMIT = 2000;
   localparam int RX_LIMIT   = 20000;

   logic              clk;
   logic              rst_clk;
   stream_beat_t      in_i;
   logic              in_valid_i;
   logic              in_ready_o;
   stream_beat_t      out_o;
   logic              out_valid_o;
   logic              out_ready_i;
   logic              start_replay_i;
   logic              sw_rst_i;
   logic [`CNT_W-1:0] replay_count_i;
   logic              busy_o;

   logic [31:0]  rng_q;
   // Packet being built, store contents as they replay, beats still due
   stream_beat_t pkt_q [$];
   stream_beat_t store_q [$];
   stream_beat_t exp_q [$];

   tb_clkgen u_tb_clkgen (
      .clk     (clk),
      .rst_clk (rst_clk)
   );

   pkt_replay_top u_pkt_replay_top (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .in_i           (in_i),
      .in_valid_i     (in_valid_i),
      .in_ready_o     (in_ready_o),
      .out_o          (out_o),
      .out_valid_o    (out_valid_o),
      .out_ready_i    (out_ready_i),
      .start_replay_i (start_replay_i),
      .sw_rst_i       (sw_rst_i),
      .replay_count_i (replay_count_i),
      .busy_o         (busy_o)
   );

   // Xorshift32
   function automatic logic [31:0] next_rand();
      rng_q = rng_q ^ (rng_q << 13);
      rng_q = rng_q ^ (rng_q >> 17);
      rng_q = rng_q ^ (rng_q << 5);
      return rng_q;
   endfunction

   function automatic logic [`KEEP_W-1:0] keep_mask(input int nbytes);
      logic [`KEEP_W-1:0] m;
      m = '0;
      for (int i = 0; i < `KEEP_W; i++) begin
         m[i] = (i < nbytes);
      end
      return m;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_beat(input string name, input stream_beat_t got,
                             input stream_beat_t exp);
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         stop_run("output beat mismatch");
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         stop_run("control level mismatch");
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_busy(input logic level);
      int waited;
      waited = 0;
      while (busy_o !== level) begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            stop_run("timeout while waiting for busy_o to change");
         end
      end
   endtask

   task automatic make_random_packet();
      logic [31:0]        r;
      logic [`USER_W-1:0] user;
      int                 nbeats;
      stream_beat_t       b;
      pkt_q.delete();
      r      = next_rand();
      nbeats = int'(r[1:0]) + 1;
      user   = next_rand();
      for (int i = 0; i < nbeats; i++) begin
         r      = next_rand();
         b.data = {next_rand(), next_rand(), next_rand(), next_rand()};
         b.keep = keep_mask(int'(r[3:0]) + 1);
         b.user = user;
         b.last = (i == nbeats - 1);
         pkt_q.push_back(b);
      end
   endtask

   // Header cycle first, then one transfer per beat
   task automatic send_packet();
      stream_beat_t b;
      int           waited;
      for (int i = 0; i < pkt_q.size(); i++) begin
         in_i       = pkt_q[i];
         in_valid_i = 1'b1;
         waited     = 0;
         while (!in_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
               stop_run("timeout while waiting for in_ready_o");
            end
         end
         @(negedge clk);
         b = pkt_q[i];
         if (i != 0) begin
            b.user = '0;
         end
         store_q.push_back(b);
      end
      in_valid_i = 1'b0;
   endtask

   task automatic expect_passes(input logic [`CNT_W-1:0] count);
      int passes;
      exp_q.delete();
      passes = (count == 0) ? 1 : int'(count);
      repeat (passes) begin
         foreach (store_q[i]) begin
            exp_q.push_back(store_q[i]);
         end
      end
   endtask

   task automatic start_replay(input logic [`CNT_W-1:0] count);
      out_ready_i    = 1'b0;
      replay_count_i = count;
      start_replay_i = 1'b1;
      wait_busy(1'b1);
      start_replay_i = 1'b0;
   endtask

   task automatic receive_expected(input logic random_ready);
      logic [31:0]  r;
      stream_beat_t exp_beat;
      int           waited;
      waited = 0;
      while (exp_q.size() > 0) begin
         @(negedge clk);
         r           = next_rand();
         out_ready_i = random_ready ? (r[0] | r[1]) : 1'b1;
         // Transfer happens on the coming rising edge
         if (out_valid_o && out_ready_i) begin
            exp_beat = exp_q.pop_front();
            check_beat("out_o", out_o, exp_beat);
         end
         waited++;
         if (waited > RX_LIMIT) begin
            stop_run("timeout while waiting for replayed beats");
         end
      end
      // Last transfer completes, then any extra beat stays in the FIFO
      @(negedge clk);
      out_ready_i = 1'b0;
   endtask

   task automatic run_replay(input logic [`CNT_W-1:0] count, input logic random_ready);
      expect_passes(count);
      start_replay(count);
      receive_expected(random_ready);
      wait_busy(1'b0);
      idle_cycles(3);
      // Nothing beyond the expected beats
      check_level("out_valid_o", out_valid_o, 1'b0);
      check_level("busy_o", busy_o, 1'b0);
   endtask

   task automatic clear_engine();
      sw_rst_i = 1'b1;
      idle_cycles(4);
      check_level("busy_o", busy_o, 1'b0);
      check_level("out_valid_o", out_valid_o, 1'b0);
      sw_rst_i = 1'b0;
      // Synchronised clear level has to drop before a new start
      idle_cycles(4);
      store_q.delete();
   endtask

   task automatic test_reset_state();
      check_level("out_valid_o", out_valid_o, 1'b0);
      check_level("in_ready_o", in_ready_o, 1'b0);
      check_level("busy_o", busy_o, 1'b0);
   endtask

   task automatic test_single_packet();
      stream_beat_t b;
      pkt_q.delete();
      for (int i = 0; i < 3; i++) begin
         b.data = {next_rand(), next_rand(), next_rand(), next_rand()};
         b.keep = (i == 2) ? 16'h003f : 16'hffff;
         b.user = 32'h5eed0001;
         b.last = (i == 2);
         pkt_q.push_back(b);
      end
      send_packet();
      run_replay(1, 1'b0);
   endtask

   task automatic test_two_packets();
      clear_engine();
      make_random_packet();
      send_packet();
      make_random_packet();
      send_packet();
      run_replay(3, 1'b0);
   endtask

   task automatic test_clear_during_replay();
      // Output held off so the replay stalls with the FIFO full
      start_replay(50);
      idle_cycles(30);
      check_level("busy_o", busy_o, 1'b1);
      clear_engine();
      make_random_packet();
      send_packet();
      run_replay(1, 1'b0);
   endtask

   initial begin
      int waited;
      rng_q          = 32'h6d6daa5c;
      in_i           = '0;
      in_valid_i     = 1'b0;
      out_ready_i    = 1'b1;
      start_replay_i = 1'b0;
      sw_rst_i       = 1'b0;
      replay_count_i = '0;
      waited         = 0;
      while (rst_clk !== 1'b0) begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            stop_run("timeout while waiting for reset to end");
         end
      end
      @(negedge clk);
      test_reset_state();
      test_single_packet();
      test_two_packets();
      // Same store under random back-pressure
      run_replay(3, 1'b1);
      run_replay(0, 1'b0);
      test_clear_during_replay();
      $display("Finished with no errors");
      $finish;
   end

endmodule
